//--- icache_top.f
design/icache_pkg.sv
design/icache_fetch_port.sv
design/icache_lookup.sv
design/icache_refill.sv
design/icache_top.sv
testbench/tb_fill_memory.sv
testbench/tb_icache.sv

//--- Bender.yml
package:
  name: icache

sources:
  - design/icache_pkg.sv
  - design/icache_fetch_port.sv
  - design/icache_lookup.sv
  - design/icache_refill.sv
  - design/icache_top.sv
  - target: test
    files:
      - testbench/tb_fill_memory.sv
      - testbench/tb_icache.sv

//--- testbench/tb_icache.sv
// ##############################
// Instruction cache testbench with clock,
// reset, directed and random fetches, and
// concurrent assertions for the checks
// ##############################

`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  localparam int unsigned TIMEOUT_CYCLES = 100;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 inst_valid;
  logic [icache_pkg::FETCH_AW-1:0]      inst_addr;
  logic                                 inst_cacheable;
  logic                                 inst_ready;
  logic [icache_pkg::FETCH_DW-1:0]      inst_data;
  logic                                 inst_error;
  logic                                 flush_valid;
  logic                                 flush_ready;
  icache_pkg::fill_req_t                fill_req;
  logic                                 fill_req_valid;
  logic                                 fill_req_ready;
  icache_pkg::fill_rsp_t                fill_rsp;
  logic                                 fill_rsp_valid;
  logic [1:0][icache_pkg::FETCH_AW-1:0] err_lines;
  int unsigned                          accept_count;

  // Expected response of the current fetch and the reference tag model behind it
  logic                                 started;
  logic [icache_pkg::FETCH_AW-1:0]      exp_addr;
  logic                                 exp_cacheable;
  logic                                 exp_hit;
  logic                                 exp_error;
  logic [icache_pkg::FETCH_DW-1:0]      exp_data;
  int unsigned                          exp_fills;
  logic [icache_pkg::LINE_COUNT-1:0]    ref_valid;
  logic [icache_pkg::TAG_WIDTH-1:0]     ref_tag [icache_pkg::LINE_COUNT];

  icache_top i_dut (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .inst_valid_i     ( inst_valid     ),
    .inst_addr_i      ( inst_addr      ),
    .inst_cacheable_i ( inst_cacheable ),
    .inst_ready_o     ( inst_ready     ),
    .inst_data_o      ( inst_data      ),
    .inst_error_o     ( inst_error     ),
    .flush_valid_i    ( flush_valid    ),
    .flush_ready_o    ( flush_ready    ),
    .fill_req_o       ( fill_req       ),
    .fill_req_valid_o ( fill_req_valid ),
    .fill_req_ready_i ( fill_req_ready ),
    .fill_rsp_i       ( fill_rsp       ),
    .fill_rsp_valid_i ( fill_rsp_valid )
  );

  tb_fill_memory i_fill_memory (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .fill_req_i       ( fill_req       ),
    .fill_req_valid_i ( fill_req_valid ),
    .fill_req_ready_o ( fill_req_ready ),
    .fill_rsp_o       ( fill_rsp       ),
    .fill_rsp_valid_o ( fill_rsp_valid ),
    .err_lines_i      ( err_lines      ),
    .accept_count_o   ( accept_count   )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic end_with_failure();
    $display("test failed");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic report_value_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    end_with_failure();
  endtask

  assert property (@(posedge clk) disable iff (!rst_n)
    !started |-> !inst_ready && !flush_ready && !fill_req_valid)
    else report_value_error("Output active before the first request");

  assert property (@(posedge clk) disable iff (!rst_n)
    inst_ready |-> inst_error == exp_error && (exp_error || inst_data == exp_data))
    else report_value_error($sformatf("Fetch %h returned data %h error %b, expected %h %b",
      exp_addr, $sampled(inst_data), $sampled(inst_error), exp_data, exp_error));

  assert property (@(posedge clk) disable iff (!rst_n)
    inst_ready |-> accept_count == exp_fills)
    else report_value_error($sformatf("Fetch %h done after %0d fill requests, expected %0d",
      exp_addr, $sampled(accept_count), exp_fills));

  assert property (@(posedge clk) disable iff (!rst_n) accept_count <= exp_fills)
    else report_value_error("More fill requests than expected");

  assert property (@(posedge clk) disable iff (!rst_n)
    fill_req_valid |-> fill_req.bypass == !exp_cacheable &&
                       fill_req.addr == {exp_addr[icache_pkg::FETCH_AW-1:4], 4'h0})
    else report_value_error($sformatf("Fill request %h bypass %b for fetch %h",
      $sampled(fill_req.addr), $sampled(fill_req.bypass), exp_addr));

  assert property (@(posedge clk) disable iff (!rst_n)
    fill_req_valid && !fill_req_ready |=> fill_req_valid && $stable(fill_req))
    else report_value_error("Fill request dropped or changed while stalled");

  // A hit completes on the second edge after the fetch is captured
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(inst_valid) && exp_hit |-> !inst_ready [*3] ##1 inst_ready)
    else report_value_error($sformatf("Hit latency wrong for fetch %h", exp_addr));

  assert property (@(posedge clk) disable iff (!rst_n) inst_ready |=> !inst_ready)
    else report_value_error("inst_ready_o high for more than one cycle");

  assert property (@(posedge clk) disable iff (!rst_n)
    flush_ready |-> flush_valid ##1 !flush_ready)
    else report_value_error("flush_ready_o without a flush request or longer than a pulse");

  task automatic fetch_word(input logic [icache_pkg::FETCH_AW-1:0] addr, input logic cacheable);
    logic [icache_pkg::INDEX_WIDTH-1:0] idx;
    logic [icache_pkg::TAG_WIDTH-1:0]   tag;
    logic                               err;
    logic                               hit;
    logic                               done;
    int unsigned                        cycles;
    idx = addr[icache_pkg::LINE_ALIGN +: icache_pkg::INDEX_WIDTH];
    tag = addr[icache_pkg::FETCH_AW-1 -: icache_pkg::TAG_WIDTH];
    err = ({addr[31:4], 4'h0} == err_lines[0]) || ({addr[31:4], 4'h0} == err_lines[1]);
    hit = cacheable && ref_valid[idx] && ref_tag[idx] == tag;
    exp_addr      = addr;
    exp_cacheable = cacheable;
    exp_hit       = hit;
    exp_error     = !hit && err;
    exp_data      = {addr[31:2], 2'b00} ^ 32'hc0de_0000;
    if (!hit) begin
      exp_fills = exp_fills + 1;
    end
    // Failed refills leave the line invalid
    if (cacheable && !hit) begin
      ref_valid[idx] = !err;
      ref_tag[idx]   = tag;
    end
    started        = 1'b1;
    inst_addr      = addr;
    inst_cacheable = cacheable;
    inst_valid     = 1'b1;
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      done   = inst_ready;
      cycles = cycles + 1;
    end
    if (!done) begin
      $display("Timeout: no inst_ready_o for the fetch of address %h", addr);
      end_with_failure();
    end
    @(posedge clk);
    #2;
    inst_valid = 1'b0;
    @(posedge clk);
    #2;
  endtask

  task automatic flush_cache();
    logic        done;
    int unsigned cycles;
    flush_valid = 1'b1;
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      done   = flush_ready;
      cycles = cycles + 1;
    end
    if (!done) begin
      $display("Timeout: the flush request was never acknowledged");
      end_with_failure();
    end
    @(posedge clk);
    #2;
    flush_valid = 1'b0;
    ref_valid   = '0;
  endtask

  initial begin
    logic [icache_pkg::FETCH_AW-1:0] base;
    logic [icache_pkg::FETCH_AW-1:0] alias_base;
    logic [icache_pkg::FETCH_AW-1:0] addr;
    int unsigned                     i;
    void'($urandom(32'h54f9149c));
    rst_n          = 1'b0;
    inst_valid     = 1'b0;
    inst_addr      = '0;
    inst_cacheable = 1'b0;
    flush_valid    = 1'b0;
    started        = 1'b0;
    exp_addr       = '0;
    exp_cacheable  = 1'b0;
    exp_hit        = 1'b0;
    exp_error      = 1'b0;
    exp_data       = '0;
    exp_fills      = 0;
    ref_valid      = '0;
    err_lines[0]   = $urandom() & 32'hffff_fff0;
    err_lines[1]   = $urandom() & 32'hffff_fff0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (3) @(posedge clk);
    #2;

    // Miss, hits on every word, then the same index with another tag
    base       = $urandom() & 32'hffff_fff0;
    alias_base = base ^ 32'h0000_1000;
    fetch_word(base + 4, 1'b1);
    for (i = 0; i < 4; i++) begin
      fetch_word(base + 4 * i, 1'b1);
    end
    fetch_word(alias_base + 8, 1'b1);
    fetch_word(alias_base, 1'b1);

    // Bypass of a line that is cached, then a flush and a refill
    fetch_word(alias_base + 12, 1'b0);
    fetch_word(alias_base + 12, 1'b1);
    flush_cache();
    fetch_word(alias_base + 4, 1'b1);

    // Error lines are reported and never stored
    fetch_word(err_lines[0] + 4, 1'b1);
    fetch_word(err_lines[0] + 8, 1'b1);
    fetch_word(err_lines[1], 1'b0);

    for (i = 0; i < 60; i++) begin
      addr = ($urandom() % 2 == 0) ? base : alias_base;
      addr[icache_pkg::LINE_ALIGN +: icache_pkg::INDEX_WIDTH] = $urandom();
      addr[3:2] = $urandom();
      fetch_word(addr, ($urandom() % 4) != 0);
      if ($urandom() % 12 == 0) begin
        flush_cache();
      end
    end

    repeat (2) @(posedge clk);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tb_fill_memory.sv
// ##############################
// Refill memory model with random
// back-pressure, response delay, error
// lines and a count of accepted requests
// ##############################

`timescale 1ns/1ps
`default_nettype none

module tb_fill_memory (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  icache_pkg::fill_req_t                fill_req_i,
  input  logic                                 fill_req_valid_i,
  output logic                                 fill_req_ready_o,
  output icache_pkg::fill_rsp_t                fill_rsp_o,
  output logic                                 fill_rsp_valid_o,
  input  logic [1:0][icache_pkg::FETCH_AW-1:0] err_lines_i,
  output int unsigned                          accept_count_o
);

  logic                            accept;
  logic                            in_reset;
  logic                            pending;
  logic [icache_pkg::FETCH_AW-1:0] line_addr;
  int unsigned                     delay;
  int unsigned                     k;

  initial begin
    fill_req_ready_o = 1'b0;
    fill_rsp_o       = '0;
    fill_rsp_valid_o = 1'b0;
    accept_count_o   = 0;
    pending          = 1'b0;
    line_addr        = '0;
    delay            = 0;
    forever begin
      // Valid and ready are both stable around the falling edge
      @(negedge clk_i);
      accept    = fill_req_valid_i && fill_req_ready_o;
      in_reset  = !rst_n_i;
      if (accept) begin
        line_addr = fill_req_i.addr;
      end
      @(posedge clk_i);
      #2;
      fill_rsp_valid_o = 1'b0;
      if (in_reset) begin
        pending          = 1'b0;
        fill_req_ready_o = 1'b0;
        accept_count_o   = 0;
      end else if (accept) begin
        accept_count_o   = accept_count_o + 1;
        pending          = 1'b1;
        delay            = $urandom() % 5;
        fill_req_ready_o = 1'b0;
      end else if (pending) begin
        if (delay == 0) begin
          // Word k of the line holds its own byte address XOR a fixed pattern
          for (k = 0; k < icache_pkg::LINE_WIDTH / icache_pkg::FETCH_DW; k++) begin
            fill_rsp_o.line[k*icache_pkg::FETCH_DW +: icache_pkg::FETCH_DW] =
              (line_addr + 4 * k) ^ 32'hc0de_0000;
          end
          fill_rsp_o.error = (line_addr == err_lines_i[0]) || (line_addr == err_lines_i[1]);
          fill_rsp_valid_o = 1'b1;
          pending          = 1'b0;
        end else begin
          delay = delay - 1;
        end
      end
      if (!in_reset && !pending) begin
        fill_req_ready_o = ($urandom() % 4) != 0;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/icache_top.sv
// ##############################
// Instruction cache top level with the
// fetch port, lookup and refill blocks
// ##############################

`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            inst_valid_i,
  input  logic [icache_pkg::FETCH_AW-1:0] inst_addr_i,
  input  logic                            inst_cacheable_i,
  output logic                            inst_ready_o,
  output logic [icache_pkg::FETCH_DW-1:0] inst_data_o,
  output logic                            inst_error_o,
  input  logic                            flush_valid_i,
  output logic                            flush_ready_o,
  output icache_pkg::fill_req_t           fill_req_o,
  output logic                            fill_req_valid_o,
  input  logic                            fill_req_ready_i,
  input  icache_pkg::fill_rsp_t           fill_rsp_i,
  input  logic                            fill_rsp_valid_i
);

  icache_pkg::fetch_req_t          lookup_req;
  logic                            lookup_req_valid;
  logic                            bypass_req_valid;
  logic [icache_pkg::FETCH_AW-1:0] bypass_addr;
  icache_pkg::line_rsp_t           cache_rsp;
  logic                            cache_rsp_valid;
  icache_pkg::fill_rsp_t           bypass_rsp;
  logic                            bypass_rsp_valid;
  logic                            miss_req_valid;
  logic [icache_pkg::FETCH_AW-1:0] miss_addr;
  icache_pkg::fill_rsp_t           miss_rsp;
  logic                            miss_rsp_valid;
  logic                            busy;

  icache_fetch_port i_fetch_port (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .inst_valid_i       ( inst_valid_i     ),
    .inst_addr_i        ( inst_addr_i      ),
    .inst_cacheable_i   ( inst_cacheable_i ),
    .inst_ready_o       ( inst_ready_o     ),
    .inst_data_o        ( inst_data_o      ),
    .inst_error_o       ( inst_error_o     ),
    .lookup_req_o       ( lookup_req       ),
    .lookup_req_valid_o ( lookup_req_valid ),
    .bypass_req_valid_o ( bypass_req_valid ),
    .bypass_addr_o      ( bypass_addr      ),
    .cache_rsp_i        ( cache_rsp        ),
    .cache_rsp_valid_i  ( cache_rsp_valid  ),
    .bypass_rsp_i       ( bypass_rsp       ),
    .bypass_rsp_valid_i ( bypass_rsp_valid ),
    .busy_o             ( busy             )
  );

  icache_lookup i_lookup (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .lookup_req_i       ( lookup_req       ),
    .lookup_req_valid_i ( lookup_req_valid ),
    .cache_rsp_o        ( cache_rsp        ),
    .cache_rsp_valid_o  ( cache_rsp_valid  ),
    .miss_req_valid_o   ( miss_req_valid   ),
    .miss_addr_o        ( miss_addr        ),
    .miss_rsp_i         ( miss_rsp         ),
    .miss_rsp_valid_i   ( miss_rsp_valid   ),
    .flush_valid_i      ( flush_valid_i    ),
    .busy_i             ( busy             ),
    .flush_ready_o      ( flush_ready_o    )
  );

  icache_refill i_refill (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .miss_req_valid_i   ( miss_req_valid   ),
    .miss_addr_i        ( miss_addr        ),
    .bypass_req_valid_i ( bypass_req_valid ),
    .bypass_addr_i      ( bypass_addr      ),
    .fill_req_o         ( fill_req_o       ),
    .fill_req_valid_o   ( fill_req_valid_o ),
    .fill_req_ready_i   ( fill_req_ready_i ),
    .fill_rsp_i         ( fill_rsp_i       ),
    .fill_rsp_valid_i   ( fill_rsp_valid_i ),
    .miss_rsp_o         ( miss_rsp         ),
    .bypass_rsp_o       ( bypass_rsp       ),
    .miss_rsp_valid_o   ( miss_rsp_valid   ),
    .bypass_rsp_valid_o ( bypass_rsp_valid )
  );

endmodule

`default_nettype wire

//--- design/icache_refill.sv
// ##############################
// Refill port holding the single
// outstanding line request and routing
// its response back
// ##############################

`timescale 1ns/1ps
`default_nettype none

module icache_refill (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            miss_req_valid_i,
  input  logic [icache_pkg::FETCH_AW-1:0] miss_addr_i,
  input  logic                            bypass_req_valid_i,
  input  logic [icache_pkg::FETCH_AW-1:0] bypass_addr_i,
  output icache_pkg::fill_req_t           fill_req_o,
  output logic                            fill_req_valid_o,
  input  logic                            fill_req_ready_i,
  input  icache_pkg::fill_rsp_t           fill_rsp_i,
  input  logic                            fill_rsp_valid_i,
  output icache_pkg::fill_rsp_t           miss_rsp_o,
  output icache_pkg::fill_rsp_t           bypass_rsp_o,
  output logic                            miss_rsp_valid_o,
  output logic                            bypass_rsp_valid_o
);

  icache_pkg::fill_req_t req_q;
  logic                  req_valid_q;
  logic                  rsp_wait_q;
  logic                  rsp_valid;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_valid_q <= 1'b0;
      rsp_wait_q  <= 1'b0;
    end else begin
      if (miss_req_valid_i || bypass_req_valid_i) begin
        req_valid_q <= 1'b1;
      end else if (req_valid_q && fill_req_ready_i) begin
        req_valid_q <= 1'b0;
        rsp_wait_q  <= 1'b1;
      end
      if (rsp_valid) begin
        rsp_wait_q <= 1'b0;
      end
    end
  end

  // Both request kinds go out line aligned and the word is picked at the fetch port
  always_ff @(posedge clk_i) begin
    if (miss_req_valid_i) begin
      req_q.addr   <= {miss_addr_i[icache_pkg::FETCH_AW-1:icache_pkg::LINE_ALIGN],
                       {icache_pkg::LINE_ALIGN{1'b0}}};
      req_q.bypass <= 1'b0;
    end else if (bypass_req_valid_i) begin
      req_q.addr   <= {bypass_addr_i[icache_pkg::FETCH_AW-1:icache_pkg::LINE_ALIGN],
                       {icache_pkg::LINE_ALIGN{1'b0}}};
      req_q.bypass <= 1'b1;
    end
  end

  assign fill_req_o       = req_q;
  assign fill_req_valid_o = req_valid_q;

  // Only the accepted request can be answered
  assign rsp_valid = rsp_wait_q && fill_rsp_valid_i;

  assign miss_rsp_o         = fill_rsp_i;
  assign bypass_rsp_o       = fill_rsp_i;
  assign miss_rsp_valid_o   = rsp_valid && !req_q.bypass;
  assign bypass_rsp_valid_o = rsp_valid && req_q.bypass;

endmodule

`default_nettype wire

//--- design/icache_lookup.sv
// ##############################
// Direct-mapped lookup with tag, valid and
// data arrays, hit check, miss handling,
// line write and flush
// ##############################

`timescale 1ns/1ps
`default_nettype none

module icache_lookup (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  icache_pkg::fetch_req_t          lookup_req_i,
  input  logic                            lookup_req_valid_i,
  output icache_pkg::line_rsp_t           cache_rsp_o,
  output logic                            cache_rsp_valid_o,
  output logic                            miss_req_valid_o,
  output logic [icache_pkg::FETCH_AW-1:0] miss_addr_o,
  input  icache_pkg::fill_rsp_t           miss_rsp_i,
  input  logic                            miss_rsp_valid_i,
  input  logic                            flush_valid_i,
  input  logic                            busy_i,
  output logic                            flush_ready_o
);

  icache_pkg::lookup_state_e                   state_q;
  icache_pkg::lookup_state_e                   state_d;
  icache_pkg::fetch_req_t                      req_q;
  logic                                        req_en;
  logic [icache_pkg::TAG_WIDTH-1:0]            tag_q   [icache_pkg::LINE_COUNT];
  logic [icache_pkg::LINE_WIDTH-1:0]           data_q  [icache_pkg::LINE_COUNT];
  logic [icache_pkg::LINE_COUNT-1:0]           valid_q;
  logic [icache_pkg::INDEX_WIDTH-1:0]          req_index;
  logic [icache_pkg::TAG_WIDTH-1:0]            req_tag;
  logic                                        hit;
  logic                                        line_write;
  logic                                        flush_clear;

  assign req_index = req_q.addr[icache_pkg::LINE_ALIGN +: icache_pkg::INDEX_WIDTH];
  assign req_tag   = req_q.addr[icache_pkg::FETCH_AW-1 -: icache_pkg::TAG_WIDTH];
  assign hit       = valid_q[req_index] && (tag_q[req_index] == req_tag);

  assign miss_addr_o = {req_tag, req_index, {icache_pkg::LINE_ALIGN{1'b0}}};

  always_comb begin
    state_d           = state_q;
    req_en            = 1'b0;
    cache_rsp_valid_o = 1'b0;
    miss_req_valid_o  = 1'b0;
    flush_ready_o     = 1'b0;
    line_write        = 1'b0;
    flush_clear       = 1'b0;
    // A refilled line is forwarded in the cycle it arrives
    if (state_q == icache_pkg::MISS_WAIT) begin
      cache_rsp_o.line  = miss_rsp_i.line;
      cache_rsp_o.error = miss_rsp_i.error;
    end else begin
      cache_rsp_o.line  = data_q[req_index];
      cache_rsp_o.error = 1'b0;
    end
    case (state_q)
      icache_pkg::IDLE: begin
        if (lookup_req_valid_i) begin
          req_en  = 1'b1;
          state_d = icache_pkg::TAG_READ;
        end else if (flush_valid_i && !busy_i) begin
          state_d = icache_pkg::FLUSH;
        end
      end
      icache_pkg::TAG_READ: begin
        if (hit) begin
          cache_rsp_valid_o = 1'b1;
          state_d           = icache_pkg::IDLE;
        end else begin
          miss_req_valid_o = 1'b1;
          state_d          = icache_pkg::MISS_WAIT;
        end
      end
      icache_pkg::MISS_WAIT: begin
        if (miss_rsp_valid_i) begin
          line_write        = 1'b1;
          cache_rsp_valid_o = 1'b1;
          state_d           = icache_pkg::IDLE;
        end
      end
      icache_pkg::FLUSH: begin
        flush_clear   = 1'b1;
        flush_ready_o = 1'b1;
        state_d       = icache_pkg::IDLE;
        // A fetch captured together with the flush is looked up after the clear
        if (lookup_req_valid_i) begin
          req_en  = 1'b1;
          state_d = icache_pkg::TAG_READ;
        end
      end
      default: state_d = icache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= icache_pkg::IDLE;
      valid_q <= '0;
    end else begin
      state_q <= state_d;
      if (flush_clear) begin
        valid_q <= '0;
      end else if (line_write) begin
        // Lines that came back with an error are never marked valid
        valid_q[req_index] <= !miss_rsp_i.error;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_en) begin
      req_q <= lookup_req_i;
    end
    if (line_write) begin
      tag_q[req_index]  <= req_tag;
      data_q[req_index] <= miss_rsp_i.line;
    end
  end

endmodule

`default_nettype wire

//--- design/icache_fetch_port.sv
// ##############################
// Fetch port of the instruction cache that
// captures one fetch, steers it to the cache
// or the bypass path and returns the word
// ##############################

`timescale 1ns/1ps
`default_nettype none

module icache_fetch_port (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            inst_valid_i,
  input  logic [icache_pkg::FETCH_AW-1:0] inst_addr_i,
  input  logic                            inst_cacheable_i,
  output logic                            inst_ready_o,
  output logic [icache_pkg::FETCH_DW-1:0] inst_data_o,
  output logic                            inst_error_o,
  output icache_pkg::fetch_req_t          lookup_req_o,
  output logic                            lookup_req_valid_o,
  output logic                            bypass_req_valid_o,
  output logic [icache_pkg::FETCH_AW-1:0] bypass_addr_o,
  input  icache_pkg::line_rsp_t           cache_rsp_i,
  input  logic                            cache_rsp_valid_i,
  input  icache_pkg::fill_rsp_t           bypass_rsp_i,
  input  logic                            bypass_rsp_valid_i,
  output logic                            busy_o
);

  icache_pkg::fetch_req_t                      req_q;
  logic                                        busy_q;
  logic                                        lookup_valid_q;
  logic                                        bypass_valid_q;
  logic                                        ready_q;
  logic [icache_pkg::FETCH_DW-1:0]             data_q;
  logic                                        error_q;
  logic                                        capture;
  logic                                        rsp_valid;
  logic [icache_pkg::LINE_WIDTH-1:0]           rsp_line;
  logic                                        rsp_error;
  logic [icache_pkg::WORD_SEL_WIDTH-1:0]       word_sel;

  // The requester still holds its valid during the ready cycle, so that
  // cycle must not start a new fetch
  assign capture = inst_valid_i && !busy_q && !ready_q;

  assign rsp_valid = busy_q && (cache_rsp_valid_i || bypass_rsp_valid_i);
  assign rsp_line  = cache_rsp_valid_i ? cache_rsp_i.line  : bypass_rsp_i.line;
  assign rsp_error = cache_rsp_valid_i ? cache_rsp_i.error : bypass_rsp_i.error;
  assign word_sel  = req_q.addr[icache_pkg::LINE_ALIGN-1:icache_pkg::WORD_ALIGN];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q         <= 1'b0;
      lookup_valid_q <= 1'b0;
      bypass_valid_q <= 1'b0;
      ready_q        <= 1'b0;
    end else begin
      // Requests to the lookup and the bypass path are single-cycle pulses
      lookup_valid_q <= capture && inst_cacheable_i;
      bypass_valid_q <= capture && !inst_cacheable_i;
      ready_q        <= rsp_valid;
      if (capture) begin
        busy_q <= 1'b1;
      end else if (rsp_valid) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      req_q <= '{addr: inst_addr_i, cacheable: inst_cacheable_i};
    end
    if (rsp_valid) begin
      data_q  <= rsp_line[word_sel*icache_pkg::FETCH_DW +: icache_pkg::FETCH_DW];
      error_q <= rsp_error;
    end
  end

  assign lookup_req_o       = req_q;
  assign lookup_req_valid_o = lookup_valid_q;
  assign bypass_req_valid_o = bypass_valid_q;
  assign bypass_addr_o      = req_q.addr;
  assign inst_ready_o       = ready_q;
  assign inst_data_o        = data_q;
  assign inst_error_o       = error_q;
  assign busy_o             = busy_q;

endmodule

`default_nettype wire

//--- design/icache_pkg.sv
// ##############################
// Instruction cache package with the
// geometry constants, the request and
// response structs and the lookup FSM states
// ##############################

`default_nettype none

package icache_pkg;

  // Fetch side geometry
  localparam int unsigned FETCH_AW = 32;
  localparam int unsigned FETCH_DW = 32;

  // Line geometry of the direct-mapped cache
  localparam int unsigned LINE_WIDTH = 128;
  localparam int unsigned LINE_COUNT = 16;

  // Address split into tag, index, word select and byte offset
  localparam int unsigned WORD_ALIGN     = 2;
  localparam int unsigned LINE_ALIGN     = 4;
  localparam int unsigned WORD_SEL_WIDTH = LINE_ALIGN - WORD_ALIGN;
  localparam int unsigned INDEX_WIDTH    = $clog2(LINE_COUNT);
  localparam int unsigned TAG_WIDTH      = FETCH_AW - LINE_ALIGN - INDEX_WIDTH;

  typedef struct packed {
    logic [FETCH_AW-1:0] addr;
    logic                cacheable;
  } fetch_req_t;

  // The bypass bit steers the response past the cache arrays
  typedef struct packed {
    logic [FETCH_AW-1:0] addr;
    logic                bypass;
  } fill_req_t;

  typedef struct packed {
    logic [LINE_WIDTH-1:0] line;
    logic                  error;
  } fill_rsp_t;

  typedef struct packed {
    logic [LINE_WIDTH-1:0] line;
    logic                  error;
  } line_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    TAG_READ,
    MISS_WAIT,
    FLUSH
  } lookup_state_e;

endpackage

`default_nettype wire
